// File: include/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// address map seen by both masters, each window is base plus size in bytes
`define SOC_BRAM_BASE  32'h0000_0000
`define SOC_BRAM_SIZE  32'h0000_1000

`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_SIZE 32'h0001_0000

`define SOC_PRINT_BASE 32'h1000_0000
`define SOC_PRINT_SIZE 32'h0000_1000

// 4 KiB of 32-bit words
`define SOC_BRAM_WORDS 1024

// CLINT register offsets inside its window
`define CLINT_MSIP        32'h0000_0000
`define CLINT_MTIMECMP_LO 32'h0000_4000
`define CLINT_MTIMECMP_HI 32'h0000_4004
`define CLINT_MTIME_LO    32'h0000_BFF8
`define CLINT_MTIME_HI    32'h0000_BFFC

`endif

// File: verilog/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  // one request on a master or slave port, valid is a single-cycle strobe
  typedef struct packed {
    logic        valid;
    logic        instr;  // set by the instruction fetch port
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // zero means a read
  } mem_req_t;

  // ready comes exactly one cycle after the matching valid
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/soc_periph_pkg.sv
`default_nettype none

package soc_periph_pkg;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } clint_half_t;

  // the timer counts as one 64-bit value but the bus reaches it one half at a time
  typedef union packed {
    logic [63:0] count;
    clint_half_t half;
  } clint_time_t;

  // character stream towards the console
  typedef struct packed {
    logic       valid;
    logic [7:0] char;
  } print_out_t;

endpackage

`default_nettype wire

// File: verilog/soc_interconnect.sv
`default_nettype none
`timescale 1ns/100ps

`include "soc_macros.svh"

module soc_interconnect import soc_bus_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  mem_req_t  imem_req_i,
  input  mem_req_t  dmem_req_i,
  output mem_rsp_t  imem_rsp_o,
  output mem_rsp_t  dmem_rsp_o,
  output mem_req_t  bram_req_o,
  output mem_req_t  print_req_o,
  output mem_req_t  clint_req_o,
  input  mem_rsp_t  bram_rsp_i,
  input  mem_rsp_t  print_rsp_i,
  input  mem_rsp_t  clint_rsp_i
);

  localparam int N_SLV     = 3;
  localparam int SLV_BRAM  = 0;
  localparam int SLV_PRINT = 1;
  localparam int SLV_CLINT = 2;

  localparam logic [31:0] SLV_BASE [N_SLV] = '{`SOC_BRAM_BASE, `SOC_PRINT_BASE, `SOC_CLINT_BASE};
  localparam logic [31:0] SLV_SIZE [N_SLV] = '{`SOC_BRAM_SIZE, `SOC_PRINT_SIZE, `SOC_CLINT_SIZE};

  mem_req_t ireq;  // instruction candidate, either the parked one or a fresh fetch
  mem_req_t hold_q;
  logic hold_vld_q;
  logic [N_SLV-1:0] isel;
  logic [N_SLV-1:0] dsel;
  logic [N_SLV-1:0] igrant;
  logic collide;
  logic [N_SLV-1:0] owner_q;  // 1 when the slave is answering the instruction port
  logic unmap_i_q;
  logic unmap_d_q;
  mem_req_t slv_req [N_SLV];
  mem_rsp_t slv_rsp [N_SLV];

  // offset wraps below the base, so one unsigned compare covers both bounds
  function automatic logic [N_SLV-1:0] decode(input mem_req_t req);
    logic [N_SLV-1:0] sel;
    for (int s = 0; s < N_SLV; s++) begin
      sel[s] = req.valid && ((req.addr - SLV_BASE[s]) < SLV_SIZE[s]);
    end
    return sel;
  endfunction

  always_comb begin
    ireq = hold_vld_q ? hold_q : imem_req_i;
    isel = decode(ireq);
    dsel = decode(dmem_req_i);
    igrant = isel & ~dsel;  // data side always wins a shared slave
    collide = |(isel & dsel);
    for (int s = 0; s < N_SLV; s++) begin
      slv_req[s] = dsel[s] ? dmem_req_i : ireq;
      slv_req[s].valid = dsel[s] | igrant[s];
      slv_req[s].addr = slv_req[s].addr - SLV_BASE[s];
    end
  end

  assign bram_req_o  = slv_req[SLV_BRAM];
  assign print_req_o = slv_req[SLV_PRINT];
  assign clint_req_o = slv_req[SLV_CLINT];

  assign slv_rsp[SLV_BRAM]  = bram_rsp_i;
  assign slv_rsp[SLV_PRINT] = print_rsp_i;
  assign slv_rsp[SLV_CLINT] = clint_rsp_i;

  // steer each answer to whoever the slave took the request from
  always_comb begin
    imem_rsp_o = '0;
    dmem_rsp_o = '0;
    for (int s = 0; s < N_SLV; s++) begin
      if (slv_rsp[s].ready) begin
        if (owner_q[s]) begin
          imem_rsp_o = slv_rsp[s];
        end else begin
          dmem_rsp_o = slv_rsp[s];
        end
      end
    end
    if (unmap_i_q) imem_rsp_o.ready = 1'b1;  // rdata stays zero
    if (unmap_d_q) dmem_rsp_o.ready = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      hold_vld_q <= 1'b0;
      owner_q <= '0;
      unmap_i_q <= 1'b0;
      unmap_d_q <= 1'b0;
    end else begin
      hold_vld_q <= collide;  // a parked fetch that loses again just stays parked
      for (int s = 0; s < N_SLV; s++) begin
        if (slv_req[s].valid) owner_q[s] <= igrant[s];
      end
      unmap_i_q <= ireq.valid && (isel == '0);
      unmap_d_q <= dmem_req_i.valid && (dsel == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (collide) hold_q <= ireq;
  end

endmodule

`default_nettype wire

// File: verilog/soc_bram.sv
`default_nettype none
`timescale 1ns/100ps

`include "soc_macros.svh"

module soc_bram import soc_bus_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  mem_req_t  req_i,
  output mem_rsp_t  rsp_o
);

  localparam int AW = $clog2(`SOC_BRAM_WORDS);

  logic [31:0] mem [`SOC_BRAM_WORDS];
  logic [AW-1:0] idx;
  logic [31:0] rdata_q;
  logic ready_q;

  assign idx = req_i.addr[AW+1:2];  // byte offset down to word index

  // read returns the old word even when the same access writes it
  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
    end
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: verilog/soc_print.sv
`default_nettype none
`timescale 1ns/100ps

module soc_print import soc_bus_pkg::*, soc_periph_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  mem_req_t  req_i,
  output mem_rsp_t  rsp_o,
  output print_out_t print_o
);

  logic ready_q;
  logic valid_q;
  logic [7:0] char_q;
  logic emit;

  assign emit = req_i.valid && (req_i.addr == 32'h0) && req_i.wstrb[0];

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid;
      valid_q <= emit;  // one strobe per character
    end
  end

  always_ff @(posedge clk) begin
    if (emit) char_q <= req_i.wdata[7:0];
  end

  assign rsp_o = '{ready: ready_q, rdata: 32'h0};  // nothing readable here
  assign print_o = '{valid: valid_q, char: char_q};

endmodule

`default_nettype wire

// File: verilog/soc_clint.sv
`default_nettype none
`timescale 1ns/100ps

`include "soc_macros.svh"

module soc_clint import soc_bus_pkg::*, soc_periph_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  mem_req_t   req_i,
  output mem_rsp_t   rsp_o,
  output logic       msip_o,
  output logic       mtip_o,
  output clint_time_t mtime_o
);

  logic msip_q, msip_d;
  clint_time_t mtimecmp_q, mtimecmp_d;
  clint_time_t mtime_q, mtime_d;
  logic mtip_q;
  logic ready_q;
  logic [31:0] rdata_q, rdata_d;
  logic wr;

  // byte lanes with a clear strobe keep their old value
  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wdata,
                                       input logic [3:0] wstrb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  always_comb begin
    wr = req_i.valid && (req_i.wstrb != 4'h0);
    msip_d = msip_q;
    mtimecmp_d = mtimecmp_q;
    mtime_d.count = mtime_q.count + 64'd1;  // a write below overrides one half
    if (wr) begin
      case (req_i.addr)
        `CLINT_MSIP: begin
          if (req_i.wstrb[0]) msip_d = req_i.wdata[0];
        end
        `CLINT_MTIMECMP_LO: mtimecmp_d.half.lo = merge(mtimecmp_q.half.lo, req_i.wdata, req_i.wstrb);
        `CLINT_MTIMECMP_HI: mtimecmp_d.half.hi = merge(mtimecmp_q.half.hi, req_i.wdata, req_i.wstrb);
        `CLINT_MTIME_LO: mtime_d.half.lo = merge(mtime_q.half.lo, req_i.wdata, req_i.wstrb);
        `CLINT_MTIME_HI: mtime_d.half.hi = merge(mtime_q.half.hi, req_i.wdata, req_i.wstrb);
        default: ;
      endcase
    end
    case (req_i.addr)
      `CLINT_MSIP:        rdata_d = {31'h0, msip_q};
      `CLINT_MTIMECMP_LO: rdata_d = mtimecmp_q.half.lo;
      `CLINT_MTIMECMP_HI: rdata_d = mtimecmp_q.half.hi;
      `CLINT_MTIME_LO:    rdata_d = mtime_q.half.lo;
      `CLINT_MTIME_HI:    rdata_d = mtime_q.half.hi;
      default:            rdata_d = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      msip_q <= 1'b0;
      mtimecmp_q <= '1;  // no timer interrupt until software sets a compare value
      mtime_q <= '0;
      mtip_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      msip_q <= msip_d;
      mtimecmp_q <= mtimecmp_d;
      mtime_q <= mtime_d;
      mtip_q <= mtime_q.count >= mtimecmp_q.count;
      ready_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid) rdata_q <= rdata_d;
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};
  assign msip_o = msip_q;
  assign mtip_o = mtip_q;
  assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// File: verilog/soc_top.sv
`default_nettype none
`timescale 1ns/100ps

module soc_top import soc_bus_pkg::*, soc_periph_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst,
  input  mem_req_t    imem_req_i,
  output mem_rsp_t    imem_rsp_o,
  input  mem_req_t    dmem_req_i,
  output mem_rsp_t    dmem_rsp_o,
  output print_out_t  print_o,
  output logic        msip_o,
  output logic        mtip_o,
  output clint_time_t mtime_o
);

  mem_req_t bram_req, print_req, clint_req;
  mem_rsp_t bram_rsp, print_rsp, clint_rsp;

  soc_interconnect i_interconnect (
    .clk         (clk),
    .rst         (rst),
    .imem_req_i  (imem_req_i),
    .dmem_req_i  (dmem_req_i),
    .imem_rsp_o  (imem_rsp_o),
    .dmem_rsp_o  (dmem_rsp_o),
    .bram_req_o  (bram_req),
    .print_req_o (print_req),
    .clint_req_o (clint_req),
    .bram_rsp_i  (bram_rsp),
    .print_rsp_i (print_rsp),
    .clint_rsp_i (clint_rsp)
  );

  soc_bram i_bram (.clk(clk), .rst(rst), .req_i(bram_req), .rsp_o(bram_rsp));

  soc_print i_print (.clk(clk), .rst(rst), .req_i(print_req), .rsp_o(print_rsp), .print_o(print_o));

  soc_clint i_clint (
    .clk     (clk),
    .rst     (rst),
    .req_i   (clint_req),
    .rsp_o   (clint_rsp),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o),
    .mtime_o (mtime_o)
  );

endmodule

`default_nettype wire

// File: verif/soc_props.sv
`default_nettype none
`timescale 1ns/100ps

module soc_props import soc_bus_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  mem_req_t        imem_req_i,
  input  mem_req_t        dmem_req_i,
  input  mem_rsp_t        imem_rsp_o,
  input  mem_rsp_t        dmem_rsp_o,
  input  mem_rsp_t        bram_rsp_i,
  input  mem_rsp_t        print_rsp_i,
  input  mem_rsp_t        clint_rsp_i,
  input  wire logic [2:0] dsel,
  input  wire logic       unmap_i_q,
  input  wire logic       unmap_d_q
);

  int fail_cnt = 0;  // read by the testbench at the end of the run

  // every answer, from a slave or from the unmapped path, reaches exactly one master
  a_one_master: assert property (@(posedge clk) disable iff (!rst)
    $countones({bram_rsp_i.ready, print_rsp_i.ready, clint_rsp_i.ready, unmap_i_q, unmap_d_q})
      == $countones({imem_rsp_o.ready, dmem_rsp_o.ready}))
    else begin
      fail_cnt++;
      $error("slave ready count differs from master ready count");
    end

  a_data_had_req: assert property (@(posedge clk) disable iff (!rst)
    dmem_rsp_o.ready |-> $past(dmem_req_i.valid))
    else begin
      fail_cnt++;
      $error("data port ready without a request one cycle earlier");
    end

  // an instruction request may have been parked for one extra cycle
  a_instr_had_req: assert property (@(posedge clk) disable iff (!rst)
    imem_rsp_o.ready |-> $past(imem_req_i.valid) || $past(imem_req_i.valid, 2))
    else begin
      fail_cnt++;
      $error("instruction port ready without an earlier request");
    end

  a_data_next_cycle: assert property (@(posedge clk) disable iff (!rst)
    |dsel |=> dmem_rsp_o.ready)
    else begin
      fail_cnt++;
      $error("mapped data request not answered in the next cycle");
    end

endmodule

`default_nettype wire

// File: verif/soc_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "soc_macros.svh"

module soc_tb import soc_bus_pkg::*, soc_periph_pkg::*; ();

  localparam int N_INIT  = 16;  // words first filled with all strobes set
  localparam int N_RAND  = 32;
  localparam int N_FETCH = 16;
  localparam int N_COLL  = 4;
  localparam int N_CHARS = 6;
  localparam int N_REQ   = N_INIT + 2 * N_RAND + N_FETCH + 2 * N_COLL + N_CHARS + 13;
  localparam int TIMEOUT = N_REQ * 4 + 100;
  localparam mem_req_t IDLE = '0;

  typedef struct packed {
    logic [31:0] cyc;
    logic [31:0] data;
  } expect_t;

  logic clk;
  logic rst;
  mem_req_t imem_req;
  mem_req_t dmem_req;
  mem_rsp_t imem_rsp;
  mem_rsp_t dmem_rsp;
  print_out_t print_out;
  logic msip;
  logic mtip;
  clint_time_t mtime;

  int cyc;
  int errors;
  int checks;
  int afails;
  string test_name;
  logic [31:0] lfsr;
  logic [63:0] mtime_ref;  // free-running copy of mtime, never written by the tests
  logic [31:0] ram_model [`SOC_BRAM_WORDS];
  logic msip_model;
  logic [63:0] mtimecmp_model;
  logic late;
  expect_t iq[$];
  expect_t dq[$];
  logic [7:0] chars_exp[$];

  soc_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .imem_req_i (imem_req),
    .imem_rsp_o (imem_rsp),
    .dmem_req_i (dmem_req),
    .dmem_rsp_o (dmem_rsp),
    .print_o    (print_out),
    .msip_o     (msip),
    .mtip_o     (mtip),
    .mtime_o    (mtime)
  );

  bind soc_interconnect soc_props i_props (
    .clk         (clk),
    .rst         (rst),
    .imem_req_i  (imem_req_i),
    .dmem_req_i  (dmem_req_i),
    .imem_rsp_o  (imem_rsp_o),
    .dmem_rsp_o  (dmem_rsp_o),
    .bram_rsp_i  (bram_rsp_i),
    .print_rsp_i (print_rsp_i),
    .clint_rsp_i (clint_rsp_i),
    .dsel        (dsel),
    .unmap_i_q   (unmap_i_q),
    .unmap_d_q   (unmap_d_q)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    mtime_ref <= rst ? mtime_ref + 64'd1 : 64'd0;
  end

  always @(posedge clk) begin
    if (cyc >= TIMEOUT) begin
      $display("timeout after %0d cycles, a response never arrived", cyc);
      $display("Verification failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1, the shifted-in bit is the bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // 0 ram, 1 print, 2 clint, 3 unmapped
  function automatic int slave_of(input logic [31:0] addr);
    if (addr - `SOC_BRAM_BASE < `SOC_BRAM_SIZE) return 0;
    if (addr - `SOC_PRINT_BASE < `SOC_PRINT_SIZE) return 1;
    if (addr - `SOC_CLINT_BASE < `SOC_CLINT_SIZE) return 2;
    return 3;
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `SOC_CLINT_BASE;
    case (slave_of(addr))
      0: return ram_model[addr[11:2]];
      2: begin
        case (off)
          `CLINT_MSIP:        return {31'h0, msip_model};
          `CLINT_MTIMECMP_LO: return mtimecmp_model[31:0];
          `CLINT_MTIMECMP_HI: return mtimecmp_model[63:32];
          `CLINT_MTIME_LO:    return mtime_ref[31:0];
          `CLINT_MTIME_HI:    return mtime_ref[63:32];
          default:            return 32'h0;
        endcase
      end
      default: return 32'h0;  // print port and holes in the map
    endcase
  endfunction

  function automatic void model_write(input mem_req_t req);
    logic [31:0] off;
    off = req.addr - `SOC_CLINT_BASE;
    for (int b = 0; b < 4; b++) begin
      if (req.wstrb[b] && slave_of(req.addr) == 0) begin
        ram_model[req.addr[11:2]][8*b +: 8] = req.wdata[8*b +: 8];
      end
      if (req.wstrb[b] && slave_of(req.addr) == 2) begin
        if (off == `CLINT_MTIMECMP_LO) mtimecmp_model[8*b +: 8] = req.wdata[8*b +: 8];
        if (off == `CLINT_MTIMECMP_HI) mtimecmp_model[32+8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
    if (slave_of(req.addr) == 2 && off == `CLINT_MSIP && req.wstrb[0]) msip_model = req.wdata[0];
    if (req.addr == `SOC_PRINT_BASE && req.wstrb[0]) chars_exp.push_back(req.wdata[7:0]);
  endfunction

  function automatic mem_req_t make_req(input logic instr, input logic [31:0] addr,
                                        input logic [31:0] wdata, input logic [3:0] wstrb);
    return '{valid: 1'b1, instr: instr, addr: addr, wdata: wdata, wstrb: wstrb};
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // outputs are compared on the falling edge, half a cycle away from any update
  always @(negedge clk) begin
    if (print_out.valid) begin
      if (chars_exp.size() == 0) begin
        errors++;
        $display("print strobe in cycle %0d with no character written", cyc);
      end else begin
        check_value("print char", chars_exp.pop_front(), print_out.char);
      end
    end
    if (dmem_rsp.ready) begin
      if (dq.size() == 0) begin
        errors++;
        $display("ready on the data port in cycle %0d with no request waiting", cyc);
      end else begin
        check_value("dmem ready cycle", dq[0].cyc, cyc);
        check_value("dmem rdata", dq[0].data, dmem_rsp.rdata);
        void'(dq.pop_front());
      end
    end else if (dq.size() > 0 && int'(dq[0].cyc) < cyc) begin
      errors++;
      $display("data port never answered in cycle %0d", dq[0].cyc);
      void'(dq.pop_front());
    end
    if (imem_rsp.ready) begin
      if (iq.size() == 0) begin
        errors++;
        $display("ready on the instruction port in cycle %0d with no request waiting", cyc);
      end else begin
        check_value("imem ready cycle", iq[0].cyc, cyc);
        check_value("imem rdata", iq[0].data, imem_rsp.rdata);
        void'(iq.pop_front());
      end
    end else if (iq.size() > 0 && int'(iq[0].cyc) < cyc) begin
      errors++;
      $display("instruction port never answered in cycle %0d", iq[0].cyc);
      void'(iq.pop_front());
    end
    // data goes first, so a losing fetch sees the model after the data access
    if (dmem_req.valid) begin
      dq.push_back('{cyc: cyc + 1, data: expected_read(dmem_req.addr)});
      model_write(dmem_req);
    end
    if (imem_req.valid) begin
      late = dmem_req.valid && slave_of(imem_req.addr) != 3
             && slave_of(dmem_req.addr) == slave_of(imem_req.addr);
      iq.push_back('{cyc: cyc + (late ? 2 : 1), data: expected_read(imem_req.addr)});
      model_write(imem_req);
    end
  end

  // the queues only change on the falling edge, so they are polled on the rising one
  task automatic send(input mem_req_t dreq, input mem_req_t ireq);
    @(posedge clk);
    dmem_req <= dreq;
    imem_req <= ireq;
    @(posedge clk);
    dmem_req <= IDLE;
    imem_req <= IDLE;
    while (dq.size() > 0 || iq.size() > 0) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
    send(make_req(1'b0, addr, wdata, wstrb), IDLE);
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] addr2;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    rst = 1'b0;
    imem_req = IDLE;
    dmem_req = IDLE;
    cyc = 0;
    errors = 0;
    checks = 0;
    lfsr = 32'ha77296b8;
    msip_model = 1'b0;
    mtimecmp_model = '1;
    test_name = "reset";
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_value("imem ready", 64'd0, imem_rsp.ready);
    check_value("dmem ready", 64'd0, dmem_rsp.ready);
    check_value("print valid", 64'd0, print_out.valid);
    check_value("msip_o", 64'd0, msip);
    check_value("mtip_o", 64'd0, mtip);
    check_value("mtime_o", 64'd0, mtime.count);

    test_name = "ram";
    for (int k = 0; k < N_INIT; k++) begin
      wdata = take_bits(32);
      data_access(`SOC_BRAM_BASE + 32'(4 * k), wdata, 4'hf);
    end
    for (int k = 0; k < N_RAND; k++) begin
      addr = `SOC_BRAM_BASE + (take_bits(4) << 2);
      wdata = take_bits(32);
      wstrb = 4'(take_bits(4));
      data_access(addr, wdata, wstrb);
    end
    for (int k = 0; k < N_RAND; k++) begin
      addr = `SOC_BRAM_BASE + (take_bits(4) << 2);
      data_access(addr, 32'h0, 4'h0);
    end

    test_name = "fetch";
    for (int k = 0; k < N_FETCH; k++) begin
      addr = `SOC_BRAM_BASE + (take_bits(4) << 2);
      send(IDLE, make_req(1'b1, addr, 32'h0, 4'h0));
    end

    test_name = "collision";
    for (int k = 0; k < N_COLL; k++) begin
      addr = `SOC_BRAM_BASE + (take_bits(4) << 2);
      addr2 = `SOC_BRAM_BASE + (take_bits(4) << 2);
      send(make_req(1'b0, addr, 32'h0, 4'h0), make_req(1'b1, addr2, 32'h0, 4'h0));
    end

    test_name = "print";
    for (int k = 0; k < N_CHARS; k++) begin
      wdata = {24'h0, 8'(take_bits(8))};
      data_access(`SOC_PRINT_BASE, wdata, 4'h1);
    end
    data_access(`SOC_PRINT_BASE, 32'h0, 4'h0);
    data_access(`SOC_PRINT_BASE + 32'h4, 32'h0, 4'h0);
    @(negedge clk);
    check_value("characters left", 64'd0, 64'(chars_exp.size()));

    test_name = "clint";
    data_access(`SOC_CLINT_BASE + `CLINT_MSIP, 32'h1, 4'h1);
    check_value("msip_o", 64'd1, msip);
    data_access(`SOC_CLINT_BASE + `CLINT_MSIP, 32'h0, 4'h0);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIMECMP_HI, 32'h0, 4'hf);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIMECMP_LO, 32'h10, 4'hf);
    @(negedge clk);  // the compare is registered once more
    check_value("mtip_o after low compare", 64'd1, mtip);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIMECMP_LO, 32'h0, 4'h0);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIMECMP_HI, 32'hffff_ffff, 4'hf);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIMECMP_LO, 32'hffff_ffff, 4'hf);
    @(negedge clk);
    check_value("mtip_o after compare all ones", 64'd0, mtip);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIME_LO, 32'h0, 4'h0);
    data_access(`SOC_CLINT_BASE + `CLINT_MTIME_HI, 32'h0, 4'h0);
    check_value("mtime_o", mtime_ref, mtime.count);

    test_name = "unmapped";
    data_access(32'h2000_0000, 32'h0, 4'h0);
    send(IDLE, make_req(1'b1, 32'h3000_0004, 32'h0, 4'h0));

    repeat (2) @(negedge clk);
    afails = i_dut.i_interconnect.i_props.fail_cnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: soc.f
+incdir+include
verilog/soc_bus_pkg.sv
verilog/soc_periph_pkg.sv
verilog/soc_interconnect.sv
verilog/soc_bram.sv
verilog/soc_print.sv
verilog/soc_clint.sv
verilog/soc_top.sv
verif/soc_props.sv
verif/soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= soc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the pipeline status is the status of grep, so a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
